/* verilog/net_pkg.sv */
`default_nettype none
//------------------------------------------------
// net_pkg
// shared types and protocol timing for the
// address bring-up controller
//------------------------------------------------

package net_pkg;

  //------------------------------------------------
  // bring-up stages
  //------------------------------------------------
  // order matters, everything above phy_connect needs link
  typedef enum logic [3:0] {
    start        = 4'd0,
    eeprom_start = 4'd1,   // read request out
    eeprom_read  = 4'd2,   // wait for config store
    phy_init     = 4'd3,   // init request out
    phy_connect  = 4'd4,   // wait for link
    phy_settle   = 4'd5,   // one second of quiet link
    dhcp_request = 4'd6,   // discover / request out
    dhcp_wait    = 4'd7,
    dhcp_retry   = 4'd8,   // short gap before retransmit
    running      = 4'd9,
    renew_wait   = 4'd10,  // half-lease countdown
    renew_req    = 4'd11,
    renew_ack    = 4'd12
  } bringup_state_t;

  //------------------------------------------------
  // address and counter types
  //------------------------------------------------
  typedef logic [31:0] ip_addr_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [3:0]  seconds_t;      // elapsed seconds in dhcp
  typedef logic [17:0] renew_count_t;  // seconds, or clocks for the retry gap

  //------------------------------------------------
  // protocol timing
  //------------------------------------------------
  localparam logic [15:0]  APIPA_PREFIX          = {8'd169, 8'd254};  // link-local
  localparam renew_count_t DEFAULT_RENEW_SECONDS = 18'd43_200;  // 12 h, lease of zero
  localparam renew_count_t RENEW_ACK_SECONDS     = 18'd20;      // ack window
  localparam renew_count_t RENEW_RETRY_SECONDS   = 18'd300;     // gap between renewals
  localparam seconds_t     DHCP_GIVEUP_SECONDS   = 4'd15;       // then fall back to apipa

endpackage

`default_nettype wire

/* verilog/dhcp_timer_if.sv */
`timescale 1ns/10ps
`default_nettype none
//------------------------------------------------
// dhcp_timer_if
// commands from the bring-up FSM to the timer
// block, and tick / count status back
//------------------------------------------------

interface dhcp_timer_if;
  import net_pkg::*;

  // fsm -> timers, all single-cycle commands except count_renew
  logic         restart_second;  // realign the prescaler
  logic         clear_seconds;
  logic         load_lease;      // lease/2 or default
  logic         load_renew;      // fixed seconds from renew_value
  renew_count_t renew_value;
  logic         load_gap;        // retry gap in clocks
  logic         count_renew;     // countdown enable, level

  // timers -> fsm
  logic         second_tick;     // one cycle per second
  seconds_t     seconds;
  logic         renew_zero;      // level

  modport fsm (
    output restart_second, clear_seconds, load_lease, load_renew, renew_value,
    output load_gap, count_renew,
    input  second_tick, seconds, renew_zero
  );

  modport timers (
    input  restart_second, clear_seconds, load_lease, load_renew, renew_value,
    input  load_gap, count_renew,
    output second_tick, seconds, renew_zero
  );

endinterface

`default_nettype wire

/* verilog/dhcp_timers.sv */
`timescale 1ns/10ps
`default_nettype none
//------------------------------------------------
// dhcp_timers
// one-second prescaler, elapsed-seconds counter
// and the shared renewal / retry countdown
//------------------------------------------------

module dhcp_timers #(
  parameter int CLOCKS_PER_SECOND = 2_500_000,
  parameter int RETRY_GAP_CLOCKS  = 131_072
) (
  input  wire logic        tx_clock,
  input  wire logic        rst,
  input  wire logic [31:0] lease,         // seconds, from the dhcp server
  input  wire logic        in_dhcp_wait,
  dhcp_timer_if.timers     tmr
);
  import net_pkg::*;

  localparam int PRESC_W = $clog2(CLOCKS_PER_SECOND + 1);
  localparam logic [PRESC_W-1:0] PRESC_RELOAD = PRESC_W'(CLOCKS_PER_SECOND - 1);
  localparam renew_count_t GAP_LOAD = renew_count_t'(RETRY_GAP_CLOCKS);

  logic [PRESC_W-1:0] presc;
  seconds_t           seconds_cnt;
  renew_count_t       renew_cnt;
  renew_count_t       lease_half;
  logic               gap_mode;  // countdown runs per clock, not per second

  //------------------------------------------------
  // one-second prescaler
  //------------------------------------------------
  // tick when presc hits zero, reload same cycle -> period is exact
  assign tmr.second_tick = (presc == '0);

  always_ff @(posedge tx_clock) begin
    if (rst) begin
      presc <= PRESC_RELOAD;
    end else if (tmr.restart_second || tmr.second_tick) begin
      presc <= PRESC_RELOAD;
    end else begin
      presc <= presc - 1'b1;
    end
  end

  //------------------------------------------------
  // elapsed seconds while waiting on dhcp
  //------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (rst || tmr.clear_seconds) begin
      seconds_cnt <= '0;
    end else if (in_dhcp_wait && tmr.second_tick && (seconds_cnt != '1)) begin
      seconds_cnt <= seconds_cnt + 1'b1;  // sticks at 15
    end
  end

  assign tmr.seconds = seconds_cnt;

  //------------------------------------------------
  // renewal / ack / retry countdown
  //------------------------------------------------
  // half the lease, saturating when it won't fit in 18 bits
  always_comb begin
    if (lease == '0) begin
      lease_half = DEFAULT_RENEW_SECONDS;
    end else if (lease[31:19] != '0) begin
      lease_half = '1;
    end else begin
      lease_half = lease[18:1];
    end
  end

  // last load picks the unit, loads win over counting
  always_ff @(posedge tx_clock) begin
    if (rst) begin
      renew_cnt <= '0;
      gap_mode  <= 1'b0;
    end else if (tmr.load_lease) begin
      renew_cnt <= lease_half;
      gap_mode  <= 1'b0;
    end else if (tmr.load_renew) begin
      renew_cnt <= tmr.renew_value;
      gap_mode  <= 1'b0;
    end else if (tmr.load_gap) begin
      renew_cnt <= GAP_LOAD;
      gap_mode  <= 1'b1;
    end else if (tmr.count_renew && !tmr.renew_zero &&
                 (gap_mode || tmr.second_tick)) begin
      renew_cnt <= renew_cnt - 1'b1;
    end
  end

  assign tmr.renew_zero = (renew_cnt == '0);

  // ticks stay at least two clocks apart
  tick_spacing: assert property (@(posedge tx_clock) disable iff (rst)
    tmr.second_tick |=> !tmr.second_tick);

  // the fsm never asks for two loads at once
  single_load: assert property (@(posedge tx_clock) disable iff (rst)
    $onehot0({tmr.load_lease, tmr.load_renew, tmr.load_gap}));

endmodule

`default_nettype wire

/* verilog/bringup_fsm.sv */
`timescale 1ns/10ps
`default_nettype none
//------------------------------------------------
// bringup_fsm
// steps config read, phy init, link settle and
// static / dhcp / apipa address selection, then
// keeps the dhcp lease renewed
//------------------------------------------------

module bringup_fsm (
  input  wire logic               tx_clock,
  input  wire logic               rst,
  output logic                    eeprom_rd_request,
  input  wire logic               eeprom_ready,
  input  wire net_pkg::ip_addr_t  static_ip,
  output logic                    phy_init_request,
  input  wire logic [1:0]         phy_speed,
  input  wire logic               phy_duplex,
  output logic                    dhcp_tx_enable,
  output logic                    dhcp_enable,
  input  wire logic               dhcp_success,
  input  wire net_pkg::ip_addr_t  ip_accept,
  input  wire net_pkg::mac_addr_t local_mac,
  output net_pkg::ip_addr_t       local_ip,
  output logic                    network_state,   // high = no usable address
  output logic                    static_ip_assigned,
  output logic                    dhcp_timeout,
  output logic                    in_dhcp_wait,
  dhcp_timer_if.fsm               tmr
);
  import net_pkg::*;

  bringup_state_t state;
  bringup_state_t state_next;
  ip_addr_t       local_ip_next;
  ip_addr_t       apipa_ip;
  logic           net_state_next;
  logic           link_up;

  //------------------------------------------------
  // status decode
  //------------------------------------------------
  // link: full duplex at 10 or 100 / 1000, never both speed bits equal
  assign link_up = phy_duplex && (phy_speed[1] != phy_speed[0]);
  assign static_ip_assigned = (static_ip != '1) && (static_ip != '0);
  assign apipa_ip = {APIPA_PREFIX, local_mac[15:0]};

  assign eeprom_rd_request = (state == eeprom_start);
  assign phy_init_request  = (state == phy_init);
  assign dhcp_tx_enable    = (state == dhcp_request) || (state == renew_req);  // 1-cycle states
  assign dhcp_enable       = (state inside {dhcp_request, dhcp_wait, renew_req, renew_ack});
  assign in_dhcp_wait      = (state == dhcp_wait);
  assign dhcp_timeout      = (tmr.seconds == DHCP_GIVEUP_SECONDS);

  //------------------------------------------------
  // next state and timer commands
  //------------------------------------------------
  always_comb begin
    state_next         = state;
    local_ip_next      = local_ip;
    net_state_next     = network_state;
    tmr.restart_second = 1'b0;
    tmr.clear_seconds  = 1'b0;
    tmr.load_lease     = 1'b0;
    tmr.load_renew     = 1'b0;
    tmr.renew_value    = RENEW_RETRY_SECONDS;
    tmr.load_gap       = 1'b0;
    tmr.count_renew    = 1'b0;

    if ((state > phy_connect) && !link_up) begin
      state_next     = phy_connect;  // lost link, start over from connect
      net_state_next = 1'b1;
    end else begin
      case (state)
        start:        state_next = eeprom_start;
        eeprom_start: state_next = eeprom_read;
        eeprom_read:  if (eeprom_ready) state_next = phy_init;
        phy_init:     state_next = phy_connect;

        phy_connect: begin
          if (link_up) begin
            tmr.restart_second = 1'b1;  // settle timer starts now
            state_next         = phy_settle;
          end
        end

        phy_settle: begin
          if (tmr.second_tick) begin
            if (static_ip_assigned) begin
              local_ip_next  = static_ip;
              net_state_next = 1'b0;
              state_next     = running;
            end else begin
              local_ip_next      = '0;  // 0.0.0.0 while asking
              tmr.restart_second = 1'b1;
              tmr.clear_seconds  = 1'b1;
              state_next         = dhcp_request;
            end
          end
        end

        dhcp_request: state_next = dhcp_wait;

        dhcp_wait: begin
          if (dhcp_success) begin
            local_ip_next      = ip_accept;
            net_state_next     = 1'b0;
            tmr.load_lease     = 1'b1;
            tmr.restart_second = 1'b1;
            state_next         = renew_wait;
          end else if (tmr.second_tick) begin
            // seconds still holds the old count here
            if (tmr.seconds inside {4'd0, 4'd2, 4'd6}) begin
              tmr.load_gap = 1'b1;  // retransmit at 1, 3, 7 s
              state_next   = dhcp_retry;
            end else if (tmr.seconds == DHCP_GIVEUP_SECONDS - 1'b1) begin
              local_ip_next  = apipa_ip;  // no offer, go link-local
              net_state_next = 1'b0;
              state_next     = running;
            end
          end
        end

        dhcp_retry: begin
          tmr.count_renew = 1'b1;  // gap counts clocks
          if (tmr.renew_zero) state_next = dhcp_request;
        end

        running: state_next = running;  // address held until link drops

        renew_wait: begin
          tmr.count_renew = 1'b1;
          if (tmr.renew_zero) state_next = renew_req;
        end

        renew_req: begin
          tmr.load_renew     = 1'b1;
          tmr.renew_value    = RENEW_ACK_SECONDS;
          tmr.restart_second = 1'b1;
          state_next         = renew_ack;
        end

        renew_ack: begin
          tmr.count_renew = 1'b1;
          if (dhcp_success) begin
            tmr.load_lease     = 1'b1;  // same address, new half-lease
            tmr.restart_second = 1'b1;
            state_next         = renew_wait;
          end else if (tmr.renew_zero) begin
            tmr.load_renew = 1'b1;  // no ack, try again later
            state_next     = renew_wait;
          end
        end

        default: state_next = start;
      endcase
    end
  end

  //------------------------------------------------
  // state and address registers
  //------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (rst) begin
      state         <= start;
      local_ip      <= '0;
      network_state <= 1'b1;
    end else begin
      state         <= state_next;
      local_ip      <= local_ip_next;
      network_state <= net_state_next;
    end
  end

  // one tx request per discover / renewal
  tx_single_pulse: assert property (@(posedge tx_clock) disable iff (rst)
    dhcp_tx_enable |=> !dhcp_tx_enable);

  // no usable address without link, one clock of override latency
  down_link_flagged: assert property (@(posedge tx_clock) disable iff (rst)
    !link_up |=> network_state);

endmodule

`default_nettype wire

/* verilog/net_bringup.sv */
`timescale 1ns/10ps
`default_nettype none
//------------------------------------------------
// net_bringup
// address bring-up controller, top level
//------------------------------------------------

module net_bringup #(
  parameter int CLOCKS_PER_SECOND = 2_500_000,  // prescaler length
  parameter int RETRY_GAP_CLOCKS  = 131_072     // dhcp retransmit gap
) (
  input  wire logic               tx_clock,
  input  wire logic               rst,
  // config store
  output logic                    eeprom_rd_request,
  input  wire logic               eeprom_ready,
  input  wire net_pkg::ip_addr_t  static_ip,
  // phy
  output logic                    phy_init_request,
  input  wire logic [1:0]         phy_speed,
  input  wire logic               phy_duplex,
  // dhcp engine
  output logic                    dhcp_tx_enable,
  output logic                    dhcp_enable,
  input  wire logic               dhcp_success,
  input  wire net_pkg::ip_addr_t  ip_accept,
  input  wire logic [31:0]        lease,
  // address and status
  input  wire net_pkg::mac_addr_t local_mac,
  output net_pkg::ip_addr_t       local_ip,
  output logic                    network_state,
  output logic                    static_ip_assigned,
  output logic                    dhcp_timeout
);

  logic in_dhcp_wait;

  dhcp_timer_if tmr_if ();

  dhcp_timers #(
    .CLOCKS_PER_SECOND (CLOCKS_PER_SECOND),
    .RETRY_GAP_CLOCKS  (RETRY_GAP_CLOCKS)
  ) dhcp_timers_i (
    .tx_clock     (tx_clock),
    .rst          (rst),
    .lease        (lease),
    .in_dhcp_wait (in_dhcp_wait),
    .tmr          (tmr_if.timers)
  );

  bringup_fsm bringup_fsm_i (
    .tx_clock           (tx_clock),
    .rst                (rst),
    .eeprom_rd_request  (eeprom_rd_request),
    .eeprom_ready       (eeprom_ready),
    .static_ip          (static_ip),
    .phy_init_request   (phy_init_request),
    .phy_speed          (phy_speed),
    .phy_duplex         (phy_duplex),
    .dhcp_tx_enable     (dhcp_tx_enable),
    .dhcp_enable        (dhcp_enable),
    .dhcp_success       (dhcp_success),
    .ip_accept          (ip_accept),
    .local_mac          (local_mac),
    .local_ip           (local_ip),
    .network_state      (network_state),
    .static_ip_assigned (static_ip_assigned),
    .dhcp_timeout       (dhcp_timeout),
    .in_dhcp_wait       (in_dhcp_wait),
    .tmr                (tmr_if.fsm)
  );

endmodule

`default_nettype wire

/* dv/net_bringup_tb.sv */
`timescale 1ns/10ps
`default_nettype none
//--------------------------------------------------
// net_bringup_tb
// runs the bring-up controller through reset, static,
// link loss, dhcp, renewal and apipa fallback
//--------------------------------------------------

module net_bringup_tb;
  import net_pkg::*;

  localparam int CPS = 20;  // clocks per second in the DUT
  localparam int GAP = 8;   // retry gap in clocks
  // static, relink, dhcp, two renewals, apipa
  localparam int SCENARIO_SECONDS = 2 + 2 + 2 + 10 + 17;
  localparam int TIMEOUT_NS = SCENARIO_SECONDS * CPS * 4 * 2;

  typedef enum {by_static, by_dhcp, by_apipa} addr_mode_t;

  logic        tx_clock;
  logic        rst;
  logic        eeprom_rd_request;
  logic        eeprom_ready;
  ip_addr_t    static_ip;
  logic        phy_init_request;
  logic [1:0]  phy_speed;
  logic        phy_duplex;
  logic        dhcp_tx_enable;
  logic        dhcp_enable;
  logic        dhcp_success;
  ip_addr_t    ip_accept;
  logic [31:0] lease;
  mac_addr_t   local_mac;
  ip_addr_t    local_ip;
  logic        network_state;
  logic        static_ip_assigned;
  logic        dhcp_timeout;

  int          errors = 0;
  int          checks = 0;
  int          cycle = 0;          // free-running posedge count
  int          tx_pulses = 0;
  int          eeprom_pulses = 0;
  int          phy_pulses = 0;
  int          success_cycle = 0;  // cycle of the last success drive
  int          tx_base;
  logic [31:0] seed;

  net_bringup #(
    .CLOCKS_PER_SECOND (CPS),
    .RETRY_GAP_CLOCKS  (GAP)
  ) net_bringup_i (
    .tx_clock           (tx_clock),
    .rst                (rst),
    .eeprom_rd_request  (eeprom_rd_request),
    .eeprom_ready       (eeprom_ready),
    .static_ip          (static_ip),
    .phy_init_request   (phy_init_request),
    .phy_speed          (phy_speed),
    .phy_duplex         (phy_duplex),
    .dhcp_tx_enable     (dhcp_tx_enable),
    .dhcp_enable        (dhcp_enable),
    .dhcp_success       (dhcp_success),
    .ip_accept          (ip_accept),
    .lease              (lease),
    .local_mac          (local_mac),
    .local_ip           (local_ip),
    .network_state      (network_state),
    .static_ip_assigned (static_ip_assigned),
    .dhcp_timeout       (dhcp_timeout)
  );

  initial begin
    tx_clock = 1'b0;
    forever #2 tx_clock = ~tx_clock;  // 4 ns period
  end

  // pulse and cycle counters
  always @(posedge tx_clock) begin
    cycle <= cycle + 1;
    if (!rst) begin
      if (dhcp_tx_enable) tx_pulses <= tx_pulses + 1;
      if (eeprom_rd_request) eeprom_pulses <= eeprom_pulses + 1;
      if (phy_init_request) phy_pulses <= phy_pulses + 1;
    end
  end

  //--------------------------------------------------
  // reference model
  //--------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic ip_addr_t expected_ip(input addr_mode_t mode, input ip_addr_t st,
                                           input ip_addr_t acc, input mac_addr_t mac);
    case (mode)
      by_static: return st;
      by_dhcp:   return acc;
      default:   return {8'd169, 8'd254, mac[15:0]};  // link-local from mac
    endcase
  endfunction

  // half the lease in clocks with 12 h for a zero lease
  function automatic int lease_half_clocks(input logic [31:0] l);
    return (l == 32'd0) ? 43200 * CPS : int'(l / 32'd2) * CPS;
  endfunction

  //--------------------------------------------------
  // compare tasks
  //--------------------------------------------------
  task automatic check_ip(input string name, input ip_addr_t got, input ip_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  //--------------------------------------------------
  // stimulus helpers
  //--------------------------------------------------
  task automatic after_edge();
    @(posedge tx_clock);
    #1;
  endtask

  task automatic set_link(input logic up);
    after_edge();
    phy_duplex = up;  // speed stays 2'b10
  endtask

  task automatic wait_tx(input string what, input int max_cycles);
    int n;
    n = 0;
    @(negedge tx_clock);
    while (dhcp_tx_enable !== 1'b1 && n < max_cycles) begin
      @(negedge tx_clock);
      n++;
    end
    if (dhcp_tx_enable !== 1'b1) begin
      errors++;
      $display("ERROR: t=%0t no dhcp_tx_enable for %s in %0d cycles", $time, what, max_cycles);
    end
  endtask

  task automatic wait_net_low(input string what, input int max_cycles);
    int n;
    n = 0;
    @(negedge tx_clock);
    while (network_state !== 1'b0 && n < max_cycles) begin
      @(negedge tx_clock);
      n++;
    end
    if (network_state !== 1'b0) begin
      errors++;
      $display("ERROR: t=%0t no address after %s in %0d cycles", $time, what, max_cycles);
    end
  endtask

  task automatic pulse_success();
    after_edge();
    dhcp_success = 1'b1;
    success_cycle = cycle;
    after_edge();
    dhcp_success = 1'b0;
    @(negedge tx_clock);  // registers updated by now
  endtask

  task automatic renew_round();
    int gap;
    wait_tx("renewal", lease_half_clocks(lease) + 2 * CPS);
    gap = cycle - success_cycle;
    checks++;
    if (gap < lease_half_clocks(lease)) begin
      errors++;
      $display("ERROR: t=%0t renewal request only %0d clocks after the ack", $time, gap);
    end
    pulse_success();
    check_bit("network_state", network_state, 1'b0);
    check_ip("local_ip", local_ip, expected_ip(by_dhcp, static_ip, ip_accept, local_mac));
  endtask

  //--------------------------------------------------
  // main sequence
  //--------------------------------------------------
  initial begin
    rst = 1'b1;
    eeprom_ready = 1'b0;
    phy_speed = 2'b00;
    phy_duplex = 1'b0;
    dhcp_success = 1'b0;
    seed = 32'h5b7de2ed;
    seed = lcg_next(seed);
    static_ip = {8'd192, 8'd168, seed[31:16]};  // never zero or all ones
    seed = lcg_next(seed);
    ip_accept = {8'd10, seed[31:8]};
    seed = lcg_next(seed);
    local_mac[47:16] = seed;
    seed = lcg_next(seed);
    local_mac[15:0] = seed[31:16];
    seed = lcg_next(seed);
    lease = 32'd2 + {29'd0, seed[30:28]};  // 2..9 s

    // reset values
    repeat (4) @(posedge tx_clock);
    @(negedge tx_clock);
    check_bit("dhcp_tx_enable", dhcp_tx_enable, 1'b0);
    check_bit("dhcp_enable", dhcp_enable, 1'b0);
    check_bit("eeprom_rd_request", eeprom_rd_request, 1'b0);
    check_bit("phy_init_request", phy_init_request, 1'b0);
    check_bit("network_state", network_state, 1'b1);
    check_ip("local_ip", local_ip, '0);
    after_edge();
    rst = 1'b0;
    repeat (4) @(negedge tx_clock);
    check_count("eeprom_rd_request pulses", eeprom_pulses, 1);
    check_count("phy_init_request pulses", phy_pulses, 0);  // not before the read

    // static address
    after_edge();
    eeprom_ready = 1'b1;
    phy_speed = 2'b10;
    phy_duplex = 1'b1;
    repeat (3) @(negedge tx_clock);
    check_count("phy_init_request pulses", phy_pulses, 1);
    wait_net_low("static select", 3 * CPS);
    check_ip("local_ip", local_ip, expected_ip(by_static, static_ip, ip_accept, local_mac));
    check_bit("static_ip_assigned", static_ip_assigned, 1'b1);
    check_bit("dhcp_enable", dhcp_enable, 1'b0);
    check_count("dhcp_tx_enable pulses", tx_pulses, 0);

    // link loss and return with a new static address
    set_link(1'b0);
    seed = lcg_next(seed);
    static_ip = {8'd192, 8'd168, seed[31:16]};
    repeat (2) @(negedge tx_clock);
    check_bit("network_state", network_state, 1'b1);
    set_link(1'b1);
    wait_net_low("link restore", 3 * CPS);
    check_ip("local_ip", local_ip, expected_ip(by_static, static_ip, ip_accept, local_mac));
    check_count("dhcp_tx_enable pulses", tx_pulses, 0);

    // dhcp success
    set_link(1'b0);
    static_ip = '0;
    repeat (2) @(negedge tx_clock);
    set_link(1'b1);
    wait_tx("discover", 3 * CPS);
    check_bit("dhcp_enable", dhcp_enable, 1'b1);
    pulse_success();
    check_count("dhcp_tx_enable pulses", tx_pulses, 1);
    check_ip("local_ip", local_ip, expected_ip(by_dhcp, static_ip, ip_accept, local_mac));
    check_bit("network_state", network_state, 1'b0);
    check_bit("static_ip_assigned", static_ip_assigned, 1'b0);
    check_bit("dhcp_timeout", dhcp_timeout, 1'b0);

    // two renewal rounds to see the re-arm
    renew_round();
    renew_round();

    // no offer at all -> apipa
    set_link(1'b0);
    repeat (2) @(negedge tx_clock);
    check_bit("network_state", network_state, 1'b1);
    tx_base = tx_pulses;
    set_link(1'b1);
    wait_net_low("dhcp give-up", 20 * CPS);
    check_count("dhcp_tx_enable pulses", tx_pulses - tx_base, 4);  // 0, 1, 3, 7 s
    check_ip("local_ip", local_ip, expected_ip(by_apipa, static_ip, ip_accept, local_mac));
    check_bit("dhcp_timeout", dhcp_timeout, 1'b1);
    check_bit("network_state", network_state, 1'b0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: run did not finish within %0d ns", TIMEOUT_NS);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
verilog/net_pkg.sv
verilog/dhcp_timer_if.sv
verilog/dhcp_timers.sv
verilog/bringup_fsm.sv
verilog/net_bringup.sv
dv/net_bringup_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := net_bringup_tb
FILE_LIST := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation FAILED"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
